//--- verilog/scan_pkg.sv
`default_nettype none
package scan_pkg;
    localparam int ADDRESS_NUMBER    = 15;  // row address bits
    localparam int COLADDR_NUMBER    = 10;  // column bits with 3 lsbs inside a burst
    localparam int NUM_RC_BURST_BITS = 22;  // {row, col8}
    localparam int NUM_XFER_BITS     = 6;   // 0 encodes 64 bursts
    localparam int FRAME_WIDTH_BITS  = 13;
    localparam int FRAME_HEIGHT_BITS = 16;
    localparam int LAST_FRAME_BITS   = 16;
    localparam int CALC_LATENCY      = 9;   // recalc to valid descriptor
    localparam int READ_START_PAGES  = 4;   // buffer pages free at read frame start
    localparam int NEED_PAGES        = 3;   // credit that turns want into need

    typedef enum logic [3:0] {
        MODE        = 4'd0,
        START_ADDR  = 4'd2,
        FRAME_SIZE  = 4'd3,
        FRAME_LAST  = 4'd4,
        FULL_WIDTH  = 4'd5,
        WINDOW_WH   = 4'd6,
        WINDOW_X0Y0 = 4'd7
    } scan_reg_e;

    typedef struct packed {
        logic       rsvd_hi;      // reserved
        logic       dis_need;
        logic       repeat_mode;  // keep frames going until disabled
        logic       single;
        logic       rst_frame;
        logic [2:0] rsvd;
        logic [1:0] extra_pages;  // pages the client holds beyond one
        logic       write;        // set for writes to memory
        logic       enable;
        logic       nreset;       // 0 holds the channel in reset
    } scan_mode_t;

    typedef struct packed {
        scan_mode_t                   mode;
        logic [FRAME_WIDTH_BITS:0]    frame_full_width;  // line pitch of 8 rows, in bursts
        logic [FRAME_WIDTH_BITS:0]    window_width;
        logic [FRAME_HEIGHT_BITS:0]   window_height;
        logic [FRAME_WIDTH_BITS-1:0]  window_x0;
        logic [FRAME_HEIGHT_BITS-1:0] window_y0;
        logic [NUM_RC_BURST_BITS-1:0] start_addr;        // current frame base
    } scan_cfg_t;

    typedef struct packed {
        logic [2:0]                bank;
        logic [ADDRESS_NUMBER-1:0] row;
        logic [COLADDR_NUMBER-4:0] col;          // column in bursts
        logic [NUM_XFER_BITS-1:0]  num128;
        logic                      partial;      // first half of a page split
        logic                      last_in_row;
        logic                      last_row;
    } scan_xfer_t;

    typedef enum logic [2:0] {
        IDLE,
        CALC,
        REQUEST,
        FRAME_END
    } scan_state_e;
endpackage
`default_nettype wire

//--- verilog/scan_regs.sv
`timescale 1ns/10ps
`default_nettype none
module scan_regs import scan_pkg::*; (
    input  wire                        mclk,
    input  wire                        mrst,
    input  wire                        cmd_we,        // register write strobe
    input  wire scan_reg_e             cmd_addr,
    input  wire [31:0]                 cmd_data,
    input  wire                        frame_go,      // frame accepted by the FSM
    output scan_cfg_t                  cfg,
    output logic                       param_write,   // any write, aligned with the new values
    output logic                       frame_enable,  // next frame_start may be taken
    output logic [LAST_FRAME_BITS-1:0] frame_number
);
    scan_mode_t                   wr_mode;      // write data seen as a mode word
    logic [NUM_RC_BURST_BITS-1:0] range_start;  // first frame of the range
    logic [NUM_RC_BURST_BITS-1:0] frame_size;   // address step between frames
    logic [LAST_FRAME_BITS-1:0]   last_frame;
    logic [NUM_RC_BURST_BITS-1:0] next_start;   // base of the next accepted frame
    logic [LAST_FRAME_BITS-1:0]   frame_cntr;   // number of the next frame
    logic                         restart;      // range restart, lags the write by one
    logic                         is_last;
    logic                         lsw_zero;     // 0 width means full 8192
    logic                         msw_zero;     // 0 height means full 65536

    assign wr_mode  = scan_mode_t'(cmd_data[$bits(scan_mode_t)-1:0]);
    assign is_last  = (frame_cntr == last_frame);
    assign lsw_zero = ~|cmd_data[FRAME_WIDTH_BITS-1:0];
    assign msw_zero = ~|cmd_data[31:16];

    always_ff @(posedge mclk) begin
        if (mrst) begin
            cfg          <= '0;
            range_start  <= '0;
            frame_size   <= '0;
            last_frame   <= '0;
            next_start   <= '0;
            frame_cntr   <= '0;
            frame_number <= '0;
            restart      <= 1'b0;
            param_write  <= 1'b0;
            frame_enable <= 1'b0;
        end else begin
            param_write <= cmd_we;
            restart     <= cmd_we && ((cmd_addr inside {START_ADDR, FRAME_SIZE, FRAME_LAST}) ||
                                      (cmd_addr == MODE && wr_mode.rst_frame));
            if (cmd_we) begin
                case (cmd_addr)
                    MODE:        cfg.mode <= wr_mode;
                    START_ADDR: begin
                        range_start <= cmd_data[NUM_RC_BURST_BITS-1:0];
                        frame_size  <= NUM_RC_BURST_BITS'(1);  // one frame until resized
                    end
                    FRAME_SIZE:  frame_size <= cmd_data[NUM_RC_BURST_BITS-1:0];
                    FRAME_LAST:  last_frame <= cmd_data[LAST_FRAME_BITS-1:0];
                    FULL_WIDTH:  cfg.frame_full_width <= {lsw_zero, cmd_data[FRAME_WIDTH_BITS-1:0]};
                    WINDOW_WH: begin
                        cfg.window_width  <= {lsw_zero, cmd_data[FRAME_WIDTH_BITS-1:0]};
                        cfg.window_height <= {msw_zero, cmd_data[31:16]};
                    end
                    WINDOW_X0Y0: begin
                        cfg.window_x0 <= cmd_data[FRAME_WIDTH_BITS-1:0];
                        cfg.window_y0 <= cmd_data[31:16];
                    end
                    default: ;
                endcase
            end
            if (restart) begin                         // back to the first frame of the range
                next_start   <= range_start;
                frame_cntr   <= '0;
                frame_number <= '0;
            end else if (frame_go) begin
                cfg.start_addr <= next_start;
                next_start     <= is_last ? range_start : next_start + frame_size;
                frame_cntr     <= is_last ? '0 : frame_cntr + 1'b1;
                frame_number   <= frame_cntr;
            end
            if ((cmd_we && cmd_addr == MODE && wr_mode.single) || cfg.mode.repeat_mode)
                frame_enable <= 1'b1;
            else if (frame_go)
                frame_enable <= 1'b0;                  // single frame used up
        end
    end
endmodule
`default_nettype wire

//--- verilog/scan_addr_calc.sv
`timescale 1ns/10ps
`default_nettype none
module scan_addr_calc import scan_pkg::*; (
    input  wire                         mclk,
    input  wire                         mrst,
    input  wire scan_cfg_t              cfg,
    input  wire                         recalc,     // restart from curr_x/curr_y
    input  wire [FRAME_WIDTH_BITS-1:0]  curr_x,     // relative to window left
    input  wire [FRAME_HEIGHT_BITS-1:0] curr_y,     // relative to window top
    input  wire                         continued,  // last start was a partial transfer
    output scan_xfer_t                  xfer,
    output logic                        calc_valid,
    output logic [NUM_XFER_BITS-1:0]    leftover    // bursts pushed past the page end
);
    logic [CALC_LATENCY-2:0]                   step;  // one-hot stage enables
    logic [FRAME_WIDTH_BITS-1:0]               frame_x;
    logic [FRAME_HEIGHT_BITS-1:0]              frame_y;
    logic [FRAME_HEIGHT_BITS:0]                next_y;
    logic [FRAME_WIDTH_BITS:0]                 row_left;  // bursts left in the line
    logic                                      cont_r;
    logic [FRAME_HEIGHT_BITS-4:0]              y8;        // line index with bank bits removed
    logic [FRAME_HEIGHT_BITS+FRAME_WIDTH_BITS-3:0] prod_w;
    logic [NUM_RC_BURST_BITS-1:0]              mul_r;
    logic [NUM_RC_BURST_BITS-1:0]              line_base;
    logic [NUM_RC_BURST_BITS-1:0]              row_col;
    logic [COLADDR_NUMBER-3:0]                 page_left;  // bursts to the page end, up to 128
    logic [NUM_XFER_BITS:0]                    lim_xfer;   // row_left capped at 64
    logic [NUM_XFER_BITS:0]                    num;
    logic                                      limited_w;
    logic                                      partial_r;
    logic                                      last_in_row_r;
    logic                                      last_row_r;

    assign prod_w    = y8 * cfg.frame_full_width;
    assign limited_w = page_left < {1'b0, lim_xfer};  // page end comes first

    always_ff @(posedge mclk) begin
        if (mrst)
            step <= '0;
        else if (recalc)
            step <= {{(CALC_LATENCY-2){1'b0}}, 1'b1};  // drops any run in flight
        else
            step <= {step[CALC_LATENCY-3:0], 1'b0};

        if (mrst || recalc)
            calc_valid <= 1'b0;
        else if (step[CALC_LATENCY-2])
            calc_valid <= 1'b1;
    end

    always_ff @(posedge mclk) begin
        if (recalc) begin
            frame_x  <= curr_x + cfg.window_x0;
            frame_y  <= curr_y + cfg.window_y0;
            next_y   <= curr_y + 1'b1;
            row_left <= cfg.window_width - curr_x;
            cont_r   <= continued;
        end
        if (step[0]) y8 <= frame_y[FRAME_HEIGHT_BITS-1:3];
        if (step[1]) mul_r <= prod_w[NUM_RC_BURST_BITS-1:0];  // top bits fall off
        if (step[2]) line_base <= cfg.start_addr + mul_r;
        if (step[3]) row_col <= line_base + frame_x;
        if (step[4]) begin
            page_left <= {1'b1, {(COLADDR_NUMBER-3){1'b0}}} - row_col[COLADDR_NUMBER-4:0];
            lim_xfer  <= (|row_left[FRAME_WIDTH_BITS:NUM_XFER_BITS]) ?
                         {1'b1, {NUM_XFER_BITS{1'b0}}} : row_left[NUM_XFER_BITS:0];
        end
        if (step[5]) begin
            partial_r <= limited_w && !cont_r;          // a continuation never splits again
            num       <= cont_r    ? {1'b0, leftover} :
                         limited_w ? page_left[NUM_XFER_BITS:0] : lim_xfer;
            if (!cont_r)
                leftover <= NUM_XFER_BITS'(lim_xfer - page_left[NUM_XFER_BITS:0]);
        end
        if (step[6]) begin
            last_in_row_r <= (row_left == num);
            last_row_r    <= (next_y == cfg.window_height);
        end
        if (step[7]) begin                              // descriptor changes only here
            xfer.bank        <= frame_y[2:0];
            xfer.row         <= row_col[NUM_RC_BURST_BITS-1:COLADDR_NUMBER-3];
            xfer.col         <= row_col[COLADDR_NUMBER-4:0];
            xfer.num128      <= num[NUM_XFER_BITS-1:0];  // 64 wraps to 0
            xfer.partial     <= partial_r;
            xfer.last_in_row <= last_in_row_r;
            xfer.last_row    <= last_row_r;
        end
    end
endmodule
`default_nettype wire

//--- verilog/scan_page_credit.sv
`timescale 1ns/10ps
`default_nettype none
module scan_page_credit import scan_pkg::*; (
    input  wire             mclk,
    input  wire             mrst,
    input  wire scan_cfg_t  cfg,
    input  wire             frame_go,
    input  wire             xfer_go,
    input  wire             partial,    // descriptor of the starting transfer
    input  wire             next_page,  // client released a buffer page
    input  wire             xfer_done,
    output logic [2:0]      page_cntr,  // pages available to the sequencer
    output logic            pending_zero
);
    logic [2:0] pending;   // started but not finished
    logic       chn_rst;
    logic       start_np;  // start that uses up a page

    assign chn_rst      = !cfg.mode.nreset;
    assign start_np     = xfer_go && !partial;  // split pair shares one page
    assign pending_zero = (pending == '0);

    always_ff @(posedge mclk) begin
        if (mrst || chn_rst)
            page_cntr <= '0;
        else if (frame_go)
            page_cntr <= cfg.mode.write ? 3'd0 : 3'(READ_START_PAGES);
        else if (start_np && !next_page)
            page_cntr <= page_cntr - 1'b1;
        else if (!start_np && next_page)
            page_cntr <= page_cntr + 1'b1;

        if (mrst || chn_rst || frame_go)
            pending <= '0;
        else if (xfer_go && !xfer_done)
            pending <= pending + 1'b1;
        else if (!xfer_go && xfer_done)
            pending <= pending - 1'b1;
    end
endmodule
`default_nettype wire

//--- verilog/scan_seq_fsm.sv
`timescale 1ns/10ps
`default_nettype none
module scan_seq_fsm import scan_pkg::*; (
    input  wire                          mclk,
    input  wire                          mrst,
    input  wire scan_cfg_t               cfg,
    input  wire                          frame_enable,
    input  wire                          param_write,
    input  wire                          frame_start,
    input  wire                          xfer_grant,
    input  wire scan_xfer_t              xfer,
    input  wire                          calc_valid,
    input  wire [2:0]                    page_cntr,
    input  wire                          pending_zero,
    output logic                         recalc,
    output logic                         frame_go,
    output logic                         xfer_go,       // any start, read or write
    output logic [FRAME_WIDTH_BITS-1:0]  curr_x,
    output logic [FRAME_HEIGHT_BITS-1:0] curr_y,
    output logic                         continued,
    output logic                         xfer_want,
    output logic                         xfer_need,
    output logic                         xfer_start_rd,
    output logic                         xfer_start_wr,
    output logic                         frame_done,
    output logic                         frame_finished
);
    scan_state_e            state;
    logic                   chn_rst;
    logic                   chn_en;
    logic                   accept;      // frame_start taken this cycle
    logic                   start;       // grant taken this cycle
    logic                   raise;       // want goes up
    logic                   need_ok;
    logic [NUM_XFER_BITS:0] num;         // decoded length, 1..64

    assign chn_rst = !cfg.mode.nreset;
    assign chn_en  = cfg.mode.nreset && cfg.mode.enable;
    assign accept  = (state == IDLE) && frame_start && frame_enable && chn_en;
    assign start   = (state == REQUEST) && xfer_grant && !chn_rst;
    assign raise   = (state == CALC) && calc_valid && !recalc && chn_en &&
                     (page_cntr > {1'b0, cfg.mode.extra_pages});
    assign need_ok = (page_cntr >= NEED_PAGES) && !cfg.mode.dis_need;
    assign num     = {xfer.num128 == '0, xfer.num128};

    always_ff @(posedge mclk) begin
        if (mrst) begin
            recalc        <= 1'b0;
            frame_go      <= 1'b0;
            xfer_go       <= 1'b0;
            xfer_start_rd <= 1'b0;
            xfer_start_wr <= 1'b0;
            frame_done    <= 1'b0;
        end else begin
            recalc        <= accept || start || param_write;  // x/y or parameters moved
            frame_go      <= accept;
            xfer_go       <= start;
            xfer_start_rd <= start && !cfg.mode.write;
            xfer_start_wr <= start && cfg.mode.write;
            frame_done    <= (state == FRAME_END) && pending_zero && !xfer_go && !chn_rst;
        end

        if (mrst || chn_rst) begin
            state          <= IDLE;
            xfer_want      <= 1'b0;
            xfer_need      <= 1'b0;
            curr_x         <= '0;
            curr_y         <= '0;
            continued      <= 1'b0;
            frame_finished <= 1'b0;
        end else begin
            case (state)
                IDLE: if (accept) begin                 // frames start at the window corner
                    state          <= CALC;
                    curr_x         <= '0;
                    curr_y         <= '0;
                    continued      <= 1'b0;
                    frame_finished <= 1'b0;
                end
                CALC: if (raise) begin
                    state     <= REQUEST;
                    xfer_want <= 1'b1;
                    xfer_need <= need_ok;
                end
                REQUEST: if (xfer_grant) begin
                    xfer_want <= 1'b0;
                    xfer_need <= 1'b0;
                    continued <= xfer.partial;
                    if (xfer.last_in_row) begin
                        curr_x <= '0;
                        curr_y <= curr_y + 1'b1;
                    end else begin
                        curr_x <= curr_x + num;
                    end
                    state <= (xfer.last_in_row && xfer.last_row) ? FRAME_END : CALC;
                end else begin
                    xfer_need <= need_ok;               // credit may rise while waiting
                end
                FRAME_END: if (pending_zero && !xfer_go) begin  // count lags the start by one
                    state          <= IDLE;
                    frame_finished <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end
endmodule
`default_nettype wire

//--- verilog/scan_linear_rw.sv
`timescale 1ns/10ps
`default_nettype none
module scan_linear_rw import scan_pkg::*; (
    input  wire                        mclk,
    input  wire                        mrst,
    input  wire                        cmd_we,
    input  wire scan_reg_e             cmd_addr,
    input  wire [31:0]                 cmd_data,
    input  wire                        frame_start,
    input  wire                        next_page,
    input  wire                        xfer_grant,
    input  wire                        xfer_done,
    output logic                       xfer_want,
    output logic                       xfer_need,
    output logic                       xfer_start_rd,
    output logic                       xfer_start_wr,
    output scan_xfer_t                 xfer,
    output logic                       cmd_wrmem,
    output logic                       frame_done,
    output logic                       frame_finished,
    output logic [LAST_FRAME_BITS-1:0] frame_number
);
    scan_cfg_t                    cfg;
    logic                         param_write;
    logic                         frame_enable;
    logic                         frame_go;
    logic                         recalc;
    logic                         calc_valid;
    logic                         xfer_go;
    logic                         continued;
    logic [FRAME_WIDTH_BITS-1:0]  curr_x;
    logic [FRAME_HEIGHT_BITS-1:0] curr_y;
    logic [2:0]                   page_cntr;
    logic                         pending_zero;

    assign cmd_wrmem = cfg.mode.write;  // 1: channel writes to memory

    scan_regs regs_i (
        .mclk, .mrst, .cmd_we, .cmd_addr, .cmd_data, .frame_go,
        .cfg, .param_write, .frame_enable, .frame_number
    );

    scan_addr_calc calc_i (
        .mclk, .mrst, .cfg, .recalc, .curr_x, .curr_y, .continued,
        .xfer, .calc_valid, .leftover ()
    );

    scan_page_credit credit_i (
        .mclk, .mrst, .cfg, .frame_go, .xfer_go, .partial (xfer.partial),
        .next_page, .xfer_done, .page_cntr, .pending_zero
    );

    scan_seq_fsm fsm_i (
        .mclk, .mrst, .cfg, .frame_enable, .param_write, .frame_start, .xfer_grant,
        .xfer, .calc_valid, .page_cntr, .pending_zero,
        .recalc, .frame_go, .xfer_go, .curr_x, .curr_y, .continued,
        .xfer_want, .xfer_need, .xfer_start_rd, .xfer_start_wr, .frame_done, .frame_finished
    );
endmodule
`default_nettype wire

//--- tb/tb_scan_linear_rw.sv
`timescale 1ns/10ps
`default_nettype none
module tb_scan_linear_rw import scan_pkg::*; ();
    localparam int FRAME_XFERS = 10 + 6 + 2 + 4 * 2 + 2;  // transfers over all test frames
    localparam int XFER_NS     = 400;                     // calc latency, grant delay, done
    localparam int SETUP_NS    = 1000;                    // reset and register writes per test
    localparam int LIMIT_NS    = 2 * (FRAME_XFERS * XFER_NS + 5 * SETUP_NS);

    logic                       mclk;
    logic                       mrst;
    logic                       cmd_we;
    scan_reg_e                  cmd_addr;
    logic [31:0]                cmd_data;
    logic                       frame_start;
    logic                       next_page;
    logic                       xfer_grant;
    logic                       xfer_done;
    logic                       xfer_want;
    logic                       xfer_need;
    logic                       xfer_start_rd;
    logic                       xfer_start_wr;
    scan_xfer_t                 xfer;
    logic                       cmd_wrmem;
    logic                       frame_done;
    logic                       frame_finished;
    logic [LAST_FRAME_BITS-1:0] frame_number;

    logic [15:0] lfsr = 16'd24374;                // grant delay source
    string       cur_test;
    int          errors;
    int          test_errs;                       // errors when the current test began
    int          bad_tests;
    int          run_tests;
    int          fdone_cnt;                       // frame_done pulses seen in this frame
    int          start_cnt;
    int          partial_cnt;
    int          m_x;                             // model position relative to the window
    int          m_y;
    int          m_left;
    bit          m_cont;                          // model flag for a block that continues a split
    int          c_x0;
    int          c_y0;
    int          c_w;
    int          c_h;
    int          c_fw;
    int          c_start;

    scan_linear_rw dut (
        .mclk, .mrst, .cmd_we, .cmd_addr, .cmd_data, .frame_start, .next_page, .xfer_grant,
        .xfer_done, .xfer_want, .xfer_need, .xfer_start_rd, .xfer_start_wr, .xfer, .cmd_wrmem,
        .frame_done, .frame_finished, .frame_number
    );

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;                  // 100 MHz
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired, the DUT stopped responding in %s", cur_test);
        $display("tests failed");
        $finish;
    end

    task automatic tick();
        @(posedge mclk);
        #1;                                       // inputs change and outputs are read here
        if (frame_done) fdone_cnt++;
        if (xfer_start_rd || xfer_start_wr) start_cnt++;
    endtask

    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = (lfsr >> 1) ^ (out ? 16'hB400 : 16'h0000);  // galois with taps 16 14 13 11
        return out;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        repeat (n) r = (r << 1) | int'(lfsr_bit());
        return r;
    endfunction

    task automatic compare_value(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (exp === act) else begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic confirm(input bit ok, input string msg);
        assert (ok) else begin
            $display("%s: %s", cur_test, msg);
            errors++;
        end
    endtask

    function automatic logic [31:0] mode_word(input bit wr, input int extra, input bit single,
                                              input bit rep, input bit no_need);
        scan_mode_t m;
        m             = '0;
        m.nreset      = 1'b1;
        m.enable      = 1'b1;
        m.write       = wr;
        m.extra_pages = 2'(extra);
        m.single      = single;
        m.repeat_mode = rep;
        m.dis_need    = no_need;
        return {19'b0, m};
    endfunction

    task automatic write_reg(input scan_reg_e addr, input logic [31:0] data);
        cmd_we   = 1'b1;
        cmd_addr = addr;
        cmd_data = data;
        tick();
        cmd_we   = 1'b0;
    endtask

    task automatic configure(input int x0, y0, w, h, fw, start, input logic [31:0] mode);
        mrst = 1'b1;
        repeat (4) tick();
        mrst = 1'b0;
        tick();
        c_x0    = x0;
        c_y0    = y0;
        c_w     = w;
        c_h     = h;
        c_fw    = fw;
        c_start = start;
        write_reg(FULL_WIDTH, 32'(fw));
        write_reg(WINDOW_WH, {16'(h), 16'(w)});
        write_reg(WINDOW_X0Y0, {16'(y0), 16'(x0)});
        write_reg(START_ADDR, 32'(start));
        write_reg(MODE, mode);                    // channel leaves reset last
        repeat (2) tick();                        // repeat mode enables one cycle later
    endtask

    // next block from the window position
    // 8 rows share one line base with one row per bank
    // a block stops at the line end, at 64 bursts and at the 128-burst page end
    task automatic predict_xfer(output scan_xfer_t exp);
        int fy;
        int addr;
        int page_left;
        int row_left;
        int lim;
        int num;
        fy        = m_y + c_y0;
        addr      = (c_start + (fy / 8) * c_fw + m_x + c_x0) % (1 << 22);
        page_left = 128 - addr % 128;
        row_left  = c_w - m_x;
        lim       = (row_left > 64) ? 64 : row_left;
        exp       = '0;
        if (m_cont) begin
            num = m_left;                         // rest of the split block
        end else if (page_left < lim) begin
            num         = page_left;
            exp.partial = 1'b1;
            m_left      = lim - page_left;
        end else begin
            num = lim;
        end
        exp.bank        = 3'(fy % 8);
        exp.row         = 15'(addr / 128);
        exp.col         = 7'(addr % 128);
        exp.num128      = 6'(num % 64);
        exp.last_in_row = (row_left == num);
        exp.last_row    = (m_y + 1 == c_h);
        m_cont          = exp.partial;
        if (exp.last_in_row) begin
            m_x = 0;
            m_y++;
        end else begin
            m_x += num;
        end
    endtask

    task automatic wait_for_want();
        while (!xfer_want) tick();
    endtask

    task automatic serve_xfer(input bit wr, output scan_xfer_t exp);
        predict_xfer(exp);
        wait_for_want();
        repeat (rand_bits(3)) tick();             // sequencer busy for 0..7 cycles
        xfer_grant = 1'b1;
        tick();
        xfer_grant = 1'b0;
        compare_value("start pulse", {wr, !wr}, {xfer_start_wr, xfer_start_rd});
        compare_value("descriptor", exp, xfer);
        compare_value("want after grant", 0, xfer_want);
        if (xfer.partial) partial_cnt++;          // split blocks the DUT started
        repeat (2) tick();
        confirm(fdone_cnt == 0, "frame_done came before the last xfer_done");
        xfer_done = 1'b1;
        next_page = !exp.partial;                 // a split pair frees one page
        tick();
        xfer_done = 1'b0;
        next_page = 1'b0;
    endtask

    task automatic launch_frame();
        m_x         = 0;
        m_y         = 0;
        m_cont      = 1'b0;
        fdone_cnt   = 0;
        frame_start = 1'b1;
        tick();
        frame_start = 1'b0;
    endtask

    task automatic finish_frame(input bit wr);
        scan_xfer_t exp;
        exp = '0;
        while (!(exp.last_in_row && exp.last_row)) begin
            serve_xfer(wr, exp);
        end
        while (fdone_cnt == 0) tick();            // latency follows the pending count
        repeat (4) tick();
        compare_value("frame_done pulses", 1, fdone_cnt);
        compare_value("frame_finished", 1, frame_finished);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        run_tests++;
        if (errors == test_errs) begin
            $display("%s: pass", cur_test);
        end else begin
            bad_tests++;
            $display("%s: FAIL, %0d errors", cur_test, errors - test_errs);
        end
    endtask

    task automatic read_frame();
        configure(5, 3, 20, 10, 40, 'h1000, mode_word(0, 0, 1, 0, 0));
        launch_frame();
        finish_frame(1'b0);
    endtask

    task automatic page_split();
        configure(120, 0, 30, 3, 256, 'h2000, mode_word(0, 0, 1, 0, 0));
        partial_cnt = 0;
        launch_frame();
        finish_frame(1'b0);
        compare_value("partial blocks", 3, partial_cnt);  // one per line
    endtask

    task automatic write_mode();
        configure(0, 0, 16, 2, 16, 'h4000, mode_word(1, 1, 1, 0, 0));
        compare_value("cmd_wrmem", 1, cmd_wrmem);
        launch_frame();
        repeat (15) tick();                       // descriptor ready without credit
        compare_value("want without credit", 0, xfer_want);
        next_page = 1'b1;
        tick();
        next_page = 1'b0;
        repeat (4) tick();
        compare_value("want at credit 1", 0, xfer_want);  // must exceed extra_pages
        next_page = 1'b1;
        tick();
        next_page = 1'b0;
        finish_frame(1'b1);
    endtask

    task automatic frame_range();
        configure(0, 0, 8, 2, 8, 'h10000, mode_word(0, 0, 0, 1, 0));
        write_reg(FRAME_SIZE, 32'h800);
        write_reg(FRAME_LAST, 32'd2);
        repeat (2) tick();
        for (int n = 0; n < 4; n++) begin
            c_start = 'h10000 + (n % 3) * 'h800;  // back to the range start after frame 2
            launch_frame();
            finish_frame(1'b0);
            compare_value("frame_number", n % 3, frame_number);
        end
    endtask

    task automatic need_and_reset();
        scan_xfer_t exp;
        configure(0, 0, 16, 2, 16, 'h3000, mode_word(0, 0, 1, 0, 0));
        launch_frame();
        wait_for_want();
        compare_value("need at credit 4", 1, xfer_need);
        serve_xfer(1'b0, exp);
        wait_for_want();
        write_reg(MODE, mode_word(0, 0, 0, 0, 1));
        repeat (2) tick();
        compare_value("want with dis_need", 1, xfer_want);
        compare_value("need with dis_need", 0, xfer_need);
        write_reg(MODE, 32'h0);                   // nreset low
        tick();
        compare_value("want in channel reset", 0, xfer_want);
        start_cnt  = 0;
        xfer_grant = 1'b1;
        tick();
        xfer_grant = 1'b0;
        repeat (10) tick();
        confirm(start_cnt == 0, "a transfer started after a grant during channel reset");
    endtask

    initial begin
        mrst        = 1'b1;
        cmd_we      = 1'b0;
        cmd_addr    = MODE;
        cmd_data    = '0;
        frame_start = 1'b0;
        next_page   = 1'b0;
        xfer_grant  = 1'b0;
        xfer_done   = 1'b0;

        begin_test("read_frame");
        read_frame();
        end_test();

        begin_test("page_split");
        page_split();
        end_test();

        begin_test("write_mode");
        write_mode();
        end_test();

        begin_test("frame_range");
        frame_range();
        end_test();

        begin_test("need_and_reset");
        need_and_reset();
        end_test();

        $display("summary: %0d run, %0d with errors, %0d check errors",
                 run_tests, bad_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end
endmodule
`default_nettype wire

//--- compile.f
verilog/scan_pkg.sv
verilog/scan_regs.sv
verilog/scan_addr_calc.sv
verilog/scan_page_credit.sv
verilog/scan_seq_fsm.sv
verilog/scan_linear_rw.sv
tb/tb_scan_linear_rw.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the result line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scan_linear_rw -f compile.f -Mdir obj_dir -o sim

out=$(obj_dir/sim)
echo "$out"
echo "$out" | grep -qx "all tests passed"
